/* Makefile */
SRCS := $(shell grep -v '^+' files.f) common/icache_config.svh

obj_dir/Vtb_icache: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module tb_icache

run: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache > sim.log 2>&1; cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* common/axi_pkg.sv */
`default_nettype none
`include "icache_config.svh"

package axi_pkg;

        typedef struct packed {
                logic [`AXI_ID_W-1:0]        arid;
                logic [`ICACHE_ADDR_W-1:0]   araddr;
                logic [`AXI_LEN_W-1:0]       arlen;
                logic [2:0]                  arsize;
                logic [1:0]                  arburst;
                logic [1:0]                  arlock;
                logic [3:0]                  arcache;
                logic [2:0]                  arprot;
        } axi_ar_t;

        typedef struct packed {
                logic [`AXI_ID_W-1:0]        rid;
                logic [`ICACHE_WORD_W-1:0]   rdata;
                logic [1:0]                  rresp;
                logic                        rlast;
        } axi_r_t;

        typedef enum logic [1:0] {
                br_idle,
                br_addr,
                br_data
        } bridge_state_t;

endpackage

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none
`include "icache_config.svh"

package cache_pkg;

        // request from the cpu, cacheable bit comes along
        typedef struct packed {
                logic [`ICACHE_ADDR_W-1:0]   addr;
                logic                        cacheable;
        } cpu_req_t;

        typedef struct packed {
                logic [`ICACHE_TAG_W-1:0]    tag;
                logic [`ICACHE_INDEX_W-1:0]  index;
                logic [`ICACHE_OFFSET_W-1:0] offset;
        } line_addr_t;

        typedef struct packed {
                line_addr_t                  addr;
                logic                        cacheable;
        } lookup_t;

        typedef enum logic {
                rd_word,
                rd_line
        } rd_type_t;

        typedef struct packed {
                rd_type_t                    rd_type;
                logic [`ICACHE_ADDR_W-1:0]   addr;
        } refill_req_t;

        typedef enum logic [1:0] {
                core_idle,
                core_lookup,
                core_miss,
                core_refill
        } core_state_t;

endpackage

`default_nettype wire

/* common/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address split 20 / 8 / 4
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     8
`define ICACHE_OFFSET_W    4
`define ICACHE_LINE_WORDS  4

// axi read channel
`define AXI_ID_W           4
`define AXI_LEN_W          8
`define AXI_SIZE_WORD      3'b010
`define AXI_BURST_INCR     2'b01

`endif

/* files.f */
+incdir+common
common/cache_pkg.sv
common/axi_pkg.sv
icache/line_store.sv
icache/icache_core.sv
src/fetch_port.sv
src/axi_read_bridge.sv
src/icache_top.sv
verif/axi_mem_model.sv
verif/icache_props.sv
verif/tb_icache.sv

/* icache/icache_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_core import cache_pkg::*; (
        input  wire                          clk,
        input  wire                          reset,
        input  wire                          lookup_valid,
        input  wire lookup_t                 lookup,
        output logic                         resp_valid,
        output logic [`ICACHE_WORD_W-1:0]    resp_word,
        output logic                         rd_req,
        output refill_req_t                  rd_info,
        input  wire                          rd_rdy,
        input  wire                          ret_valid,
        input  wire                          ret_last,
        input  wire [`ICACHE_WORD_W-1:0]     ret_data
);

        core_state_t                                         state;
        core_state_t                                         state_next;
        logic [`ICACHE_TAG_W-1:0]                            rd_tag;
        logic                                                rd_hit_valid;
        logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0]   line_data;
        logic [`ICACHE_OFFSET_W-3:0]                         word_sel;
        logic [`ICACHE_OFFSET_W-3:0]                         beat_cnt;
        logic [`ICACHE_WORD_W-1:0]                           resp_buf;
        logic                                                hit;
        logic                                                fill_we;
        logic                                                fill_tag_we;
        logic                                                take_beat;

        assign word_sel = lookup.addr.offset[`ICACHE_OFFSET_W-1:2];
        assign hit = lookup.cacheable && rd_hit_valid && (rd_tag == lookup.addr.tag);

        // uncacheable beats are passed on but never stored
        assign fill_we     = (state == core_refill) && ret_valid && lookup.cacheable;
        assign fill_tag_we = fill_we && ret_last;
        assign take_beat   = (state == core_refill) && ret_valid &&
                             (!lookup.cacheable || (beat_cnt == word_sel));

        line_store u_line_store (
                .clk            (clk),
                .reset          (reset),
                .rd_index       (lookup.addr.index),
                .rd_tag         (rd_tag),
                .rd_hit_valid   (rd_hit_valid),
                .rd_line        (line_data),
                .fill_we        (fill_we),
                .fill_index     (lookup.addr.index),
                .fill_word_sel  (beat_cnt),
                .fill_word      (ret_data),
                .fill_tag_we    (fill_tag_we),
                .fill_tag       (lookup.addr.tag)
        );

        always_comb begin
                state_next = state;
                case (state)
                core_idle: begin
                        if (lookup_valid && !hit) begin
                                state_next = core_miss;
                        end
                end
                core_miss: begin
                        if (rd_rdy) begin
                                state_next = core_refill;
                        end
                end
                core_refill: begin
                        if (ret_valid && ret_last) begin
                                state_next = core_lookup;
                        end
                end
                default: begin
                        state_next = core_idle;
                end
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state    <= core_idle;
                        beat_cnt <= '0;
                end else begin
                        state <= state_next;
                        if (state == core_miss) begin
                                beat_cnt <= '0;
                        end else if ((state == core_refill) && ret_valid) begin
                                beat_cnt <= beat_cnt + 1'b1;
                        end
                end
        end

        // requested word caught as it streams past
        always_ff @(posedge clk) begin
                if (take_beat) begin
                        resp_buf <= ret_data;
                end
        end

        // line aligned for a refill, exact word otherwise
        always_comb begin
                rd_info.rd_type = lookup.cacheable ? rd_line : rd_word;
                rd_info.addr    = {lookup.addr.tag, lookup.addr.index, word_sel, 2'b00};
                if (lookup.cacheable) begin
                        rd_info.addr[`ICACHE_OFFSET_W-1:0] = '0;
                end
        end

        assign rd_req     = (state == core_miss);
        assign resp_valid = ((state == core_idle) && lookup_valid && hit) ||
                            (state == core_lookup);
        assign resp_word  = (state == core_lookup) ? resp_buf : line_data[word_sel];

endmodule

`default_nettype wire

/* icache/line_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module line_store (
        input  wire                                                  clk,
        input  wire                                                  reset,
        input  wire [`ICACHE_INDEX_W-1:0]                            rd_index,
        output logic [`ICACHE_TAG_W-1:0]                             rd_tag,
        output logic                                                 rd_hit_valid,
        output logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0]    rd_line,
        input  wire                                                  fill_we,
        input  wire [`ICACHE_INDEX_W-1:0]                            fill_index,
        input  wire [`ICACHE_OFFSET_W-3:0]                           fill_word_sel,
        input  wire [`ICACHE_WORD_W-1:0]                             fill_word,
        input  wire                                                  fill_tag_we,
        input  wire [`ICACHE_TAG_W-1:0]                              fill_tag
);

        logic [`ICACHE_TAG_W-1:0]                            tag_mem  [(1<<`ICACHE_INDEX_W)];
        logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0]   data_mem [(1<<`ICACHE_INDEX_W)];
        logic [(1<<`ICACHE_INDEX_W)-1:0]                     valid_bits;

        // combinational read, all flops
        assign rd_tag       = tag_mem[rd_index];
        assign rd_hit_valid = valid_bits[rd_index];
        assign rd_line      = data_mem[rd_index];

        // one word per beat
        always_ff @(posedge clk) begin
                if (fill_we) begin
                        data_mem[fill_index][fill_word_sel] <= fill_word;
                end
                if (fill_tag_we) begin
                        tag_mem[fill_index] <= fill_tag;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_bits <= '0;
                end else if (fill_tag_we) begin
                        valid_bits[fill_index] <= 1'b1;
                end
        end

endmodule

`default_nettype wire

/* src/axi_read_bridge.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module axi_read_bridge import cache_pkg::*, axi_pkg::*; (
        input  wire                          clk,
        input  wire                          reset,
        input  wire                          rd_req,
        input  wire refill_req_t             rd_info,
        output logic                         rd_rdy,
        output logic                         ret_valid,
        output logic                         ret_last,
        output logic [`ICACHE_WORD_W-1:0]    ret_data,
        output axi_ar_t                      ar,
        output logic                         arvalid,
        input  wire                          arready,
        input  wire axi_r_t                  r,
        input  wire                          rvalid,
        output logic                         rready
);

        bridge_state_t  state;
        logic           take_req;

        assign take_req = rd_req && rd_rdy;

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= br_idle;
                end else begin
                        case (state)
                        br_idle: begin
                                if (take_req) begin
                                        state <= br_addr;
                                end
                        end
                        br_addr: begin
                                if (arready) begin
                                        state <= br_data;
                                end
                        end
                        br_data: begin
                                // burst ends on rlast
                                if (rvalid && r.rlast) begin
                                        state <= br_idle;
                                end
                        end
                        default: begin
                                state <= br_idle;
                        end
                        endcase
                end
        end

        // ar payload latched once, stable until arready
        always_ff @(posedge clk) begin
                if (take_req) begin
                        ar.arid    <= '0;
                        ar.araddr  <= rd_info.addr;
                        ar.arlen   <= (rd_info.rd_type == rd_line) ?
                                      `AXI_LEN_W'(`ICACHE_LINE_WORDS - 1) : '0;
                        ar.arsize  <= `AXI_SIZE_WORD;
                        ar.arburst <= `AXI_BURST_INCR;
                        ar.arlock  <= '0;
                        ar.arcache <= '0;
                        ar.arprot  <= '0;
                end
        end

        assign rd_rdy  = (state == br_idle);
        assign arvalid = (state == br_addr);
        assign rready  = (state == br_data);

        assign ret_valid = rvalid && rready;
        assign ret_last  = r.rlast;
        assign ret_data  = r.rdata;

endmodule

`default_nettype wire

/* src/fetch_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module fetch_port import cache_pkg::*; (
        input  wire                          clk,
        input  wire                          reset,
        input  wire                          valid,
        input  wire cpu_req_t                req,
        output logic                         addr_ok,
        output logic                         data_ok,
        output logic [`ICACHE_WORD_W-1:0]    rdata,
        output logic                         lookup_valid,
        output lookup_t                      lookup,
        input  wire                          resp_valid,
        input  wire [`ICACHE_WORD_W-1:0]     resp_word
);

        logic           busy;
        logic           accept;
        cpu_req_t       req_q;

        // one request in flight at a time
        assign addr_ok = !busy;
        assign accept  = valid && addr_ok;

        always_ff @(posedge clk) begin
                if (reset) begin
                        busy         <= 1'b0;
                        lookup_valid <= 1'b0;
                end else begin
                        lookup_valid <= accept;
                        if (accept) begin
                                busy <= 1'b1;
                        end else if (resp_valid) begin
                                busy <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        req_q <= req;
                end
        end

        // held stable until the core answers
        assign lookup.addr.tag    = req_q.addr[`ICACHE_ADDR_W-1:`ICACHE_ADDR_W-`ICACHE_TAG_W];
        assign lookup.addr.index  = req_q.addr[`ICACHE_OFFSET_W+`ICACHE_INDEX_W-1:`ICACHE_OFFSET_W];
        assign lookup.addr.offset = req_q.addr[`ICACHE_OFFSET_W-1:0];
        assign lookup.cacheable   = req_q.cacheable;

        assign data_ok = resp_valid;
        assign rdata   = resp_word;

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_top import cache_pkg::*, axi_pkg::*; (
        input  wire                          clk,
        input  wire                          reset,
        input  wire                          valid,
        input  wire cpu_req_t                req,
        output logic                         addr_ok,
        output logic                         data_ok,
        output logic [`ICACHE_WORD_W-1:0]    rdata,
        output axi_ar_t                      ar,
        output logic                         arvalid,
        input  wire                          arready,
        input  wire axi_r_t                  r,
        input  wire                          rvalid,
        output logic                         rready
);

        // fetch port <-> core
        logic                        lookup_valid;
        lookup_t                     lookup;
        logic                        resp_valid;
        logic [`ICACHE_WORD_W-1:0]   resp_word;

        // core <-> bridge
        logic                        rd_req;
        refill_req_t                 rd_info;
        logic                        rd_rdy;
        logic                        ret_valid;
        logic                        ret_last;
        logic [`ICACHE_WORD_W-1:0]   ret_data;

        fetch_port u_fetch_port (
                .clk            (clk),
                .reset          (reset),
                .valid          (valid),
                .req            (req),
                .addr_ok        (addr_ok),
                .data_ok        (data_ok),
                .rdata          (rdata),
                .lookup_valid   (lookup_valid),
                .lookup         (lookup),
                .resp_valid     (resp_valid),
                .resp_word      (resp_word)
        );

        icache_core u_icache_core (
                .clk            (clk),
                .reset          (reset),
                .lookup_valid   (lookup_valid),
                .lookup         (lookup),
                .resp_valid     (resp_valid),
                .resp_word      (resp_word),
                .rd_req         (rd_req),
                .rd_info        (rd_info),
                .rd_rdy         (rd_rdy),
                .ret_valid      (ret_valid),
                .ret_last       (ret_last),
                .ret_data       (ret_data)
        );

        axi_read_bridge u_axi_read_bridge (
                .clk            (clk),
                .reset          (reset),
                .rd_req         (rd_req),
                .rd_info        (rd_info),
                .rd_rdy         (rd_rdy),
                .ret_valid      (ret_valid),
                .ret_last       (ret_last),
                .ret_data       (ret_data),
                .ar             (ar),
                .arvalid        (arvalid),
                .arready        (arready),
                .r              (r),
                .rvalid         (rvalid),
                .rready         (rready)
        );

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import axi_pkg::*; (
        input  wire             clk,
        input  wire             reset,
        input  wire axi_ar_t    ar,
        input  wire             arvalid,
        output logic            arready,
        output axi_r_t          r,
        output logic            rvalid,
        input  wire             rready,
        input  wire [1:0]       ar_delay,
        input  wire [1:0]       r_delay,
        output logic [31:0]     beat_addr,
        input  wire [31:0]      beat_data
);

        logic           bursting;
        logic [7:0]     beats_left;
        logic [1:0]     wait_cnt;

        always_ff @(posedge clk) begin
                if (reset) begin
                        arready    <= 1'b0;
                        rvalid     <= 1'b0;
                        bursting   <= 1'b0;
                        beats_left <= '0;
                        wait_cnt   <= '0;
                        beat_addr  <= '0;
                end else if (!bursting) begin
                        arready <= 1'b0;
                        if (arvalid && arready) begin
                                bursting   <= 1'b1;
                                beat_addr  <= ar.araddr;
                                beats_left <= ar.arlen;
                        end else if (arvalid && wait_cnt == ar_delay) begin
                                arready  <= 1'b1;
                                wait_cnt <= '0;
                        end else if (arvalid) begin
                                wait_cnt <= wait_cnt + 1'b1;
                        end
                end else if (rvalid && rready) begin
                        // incrementing burst of words
                        rvalid     <= 1'b0;
                        beat_addr  <= beat_addr + 32'd4;
                        beats_left <= beats_left - 1'b1;
                        bursting   <= (beats_left != 0);
                end else if (!rvalid && wait_cnt == r_delay) begin
                        rvalid   <= 1'b1;
                        wait_cnt <= '0;
                end else if (!rvalid) begin
                        wait_cnt <= wait_cnt + 1'b1;
                end
        end

        assign r = '{rid: '0, rdata: beat_data, rresp: '0, rlast: (beats_left == 0)};

endmodule

`default_nettype wire

/* verif/icache_props.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_props import axi_pkg::*; (
        input  wire             clk,
        input  wire             reset,
        input  wire             valid,
        input  wire             addr_ok,
        input  wire             data_ok,
        input  wire axi_ar_t    ar,
        input  wire             arvalid,
        input  wire             arready
);

        logic   outstanding;

        always_ff @(posedge clk) begin
                if (reset) begin
                        outstanding <= 1'b0;
                end else if (valid && addr_ok) begin
                        outstanding <= 1'b1;
                end else if (data_ok) begin
                        outstanding <= 1'b0;
                end
        end

        ar_held: assert property (@(posedge clk) disable iff (reset)
                arvalid && !arready |=> arvalid && $stable(ar))
                else $error("ar payload or arvalid changed before arready");

        no_stray_data_ok: assert property (@(posedge clk) disable iff (reset)
                data_ok |-> outstanding)
                else $error("data_ok without an outstanding request");

        addr_ok_blocked: assert property (@(posedge clk) disable iff (reset)
                outstanding |-> !addr_ok)
                else $error("addr_ok high while a request is outstanding");

endmodule

`default_nettype wire

/* verif/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache import cache_pkg::*, axi_pkg::*; ();

        localparam int wait_limit = 200;
        localparam int random_reads = 400;
        localparam logic [19:0] tag_pool [4] = '{20'h00012, 20'h00056, 20'h0009a, 20'hfffff};
        localparam logic [7:0] idx_pool [4] = '{8'h34, 8'h12, 8'h00, 8'hff};

        logic           clk = 1'b0;
        logic           reset;
        logic           valid;
        cpu_req_t       req;
        logic           addr_ok;
        logic           data_ok;
        logic [31:0]    rdata;
        axi_ar_t        ar;
        logic           arvalid;
        logic           arready;
        axi_r_t         r;
        logic           rvalid;
        logic           rready;
        logic [1:0]     ar_delay;
        logic [1:0]     r_delay;
        logic [31:0]    beat_addr;
        logic [31:0]    beat_data;

        // expected tag and valid state of the cache
        logic [19:0]    model_tag [256];
        logic           model_valid [256];

        logic [15:0]    lfsr = 16'd60711;
        int             errors = 0;
        int             timeouts = 0;
        logic           aborted = 1'b0;
        int             cycle;
        int             ar_count;
        int             last_beat_cycle;
        logic [7:0]     exp_len;
        logic [31:0]    exp_araddr;

        icache_top u_icache_top (
                .clk(clk), .reset(reset), .valid(valid), .req(req),
                .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
                .ar(ar), .arvalid(arvalid), .arready(arready),
                .r(r), .rvalid(rvalid), .rready(rready)
        );

        axi_mem_model u_axi_mem_model (
                .clk(clk), .reset(reset), .ar(ar), .arvalid(arvalid), .arready(arready),
                .r(r), .rvalid(rvalid), .rready(rready), .ar_delay(ar_delay),
                .r_delay(r_delay), .beat_addr(beat_addr), .beat_data(beat_data)
        );

        bind icache_top icache_props u_icache_props (
                .clk(clk), .reset(reset), .valid(valid), .addr_ok(addr_ok),
                .data_ok(data_ok), .ar(ar), .arvalid(arvalid), .arready(arready)
        );

        always #50 clk = ~clk;

        // fibonacci lfsr, taps 16 14 13 11
        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                        v = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        // memory word as a fixed function of the word address
        function automatic logic [31:0] mem_word(input logic [31:0] addr);
                return ({2'b00, addr[31:2]} * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
        endfunction

        assign beat_data = mem_word(beat_addr);

        task automatic report_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] got);
                $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
                errors++;
        endtask

        always @(posedge clk) begin
                if (reset) begin
                        cycle <= 0;
                        ar_count <= 0;
                        last_beat_cycle <= 0;
                end else begin
                        cycle <= cycle + 1;
                        if (arvalid && arready) begin
                                ar_count <= ar_count + 1;
                                assert (ar.araddr == exp_araddr)
                                else report_mismatch("araddr", exp_araddr, ar.araddr);
                                assert (ar.arlen == exp_len)
                                else report_mismatch("arlen", 32'(exp_len), 32'(ar.arlen));
                                assert (ar.arsize == 3'b010)
                                else report_mismatch("arsize", 32'd2, 32'(ar.arsize));
                                assert (ar.arburst == 2'b01)
                                else report_mismatch("arburst", 32'd1, 32'(ar.arburst));
                                assert (ar.arid == '0)
                                else report_mismatch("arid", 32'd0, 32'(ar.arid));
                        end
                        if (rvalid && rready && r.rlast) begin
                                last_beat_cycle <= cycle;
                        end
                end
        end

        // one request, from drive to data_ok, checked against the model
        task automatic read_and_check(input logic [31:0] addr, input logic cached);
                logic [7:0]     idx;
                logic [19:0]    tg;
                logic           hit;
                int             ar_before;
                int             waited;
                if (aborted) return;
                idx = addr[11:4];
                tg = addr[31:12];
                hit = cached && model_valid[idx] && (model_tag[idx] == tg);
                exp_len = cached ? 8'd3 : 8'd0;
                exp_araddr = cached ? {addr[31:4], 4'h0} : {addr[31:2], 2'b00};
                ar_before = ar_count;
                valid <= 1'b1;
                req <= '{addr: addr, cacheable: cached};
                waited = 0;
                do begin
                        @(posedge clk);
                        waited++;
                end while (!addr_ok && waited < wait_limit);
                valid <= 1'b0;
                if (!addr_ok) begin
                        $display("ERROR %0t request was never accepted", $time);
                        timeouts++;
                        aborted = 1'b1;
                        return;
                end
                waited = 0;
                do begin
                        @(posedge clk);
                        waited++;
                        assert (!addr_ok) else begin
                                $display("ERROR %0t addr_ok high with a request in flight", $time);
                                errors++;
                        end
                end while (!data_ok && waited < wait_limit);
                if (!data_ok) begin
                        $display("ERROR %0t no data_ok for address %h", $time, addr);
                        timeouts++;
                        aborted = 1'b1;
                        return;
                end
                assert (rdata == mem_word(addr))
                else report_mismatch("rdata", mem_word(addr), rdata);
                if (hit) begin
                        assert (waited == 1) else report_mismatch("data_ok latency", 1, waited);
                        assert (ar_count == ar_before)
                        else report_mismatch("ar_count", ar_before, ar_count);
                end else begin
                        assert (ar_count == ar_before + 1)
                        else report_mismatch("ar_count", ar_before + 1, ar_count);
                        assert (cycle == last_beat_cycle + 1)
                        else report_mismatch("data_ok cycle", last_beat_cycle + 1, cycle);
                end
                if (cached && !hit) begin
                        model_tag[idx] = tg;
                        model_valid[idx] = 1'b1;
                end
        endtask

        initial begin
                logic [19:0]    pick_tag;
                logic [7:0]     pick_idx;
                logic [1:0]     pick_word;
                logic           pick_cached;
                for (int i = 0; i < 256; i++) begin
                        model_valid[i] = 1'b0;
                end
                reset <= 1'b1;
                valid <= 1'b0;
                req <= '0;
                ar_delay <= 2'd1;
                r_delay <= 2'd1;
                repeat (16) @(posedge clk);
                reset <= 1'b0;
                // idle after reset
                for (int i = 0; i < 8; i++) begin
                        @(posedge clk);
                        assert (addr_ok && !data_ok && !arvalid && !rready) else begin
                                $display("ERROR %0t handshake outputs not idle after reset", $time);
                                errors++;
                        end
                end
                assert (ar_count == 0) else report_mismatch("ar_count", 0, ar_count);

                // line miss, then hits on every word of the line
                read_and_check(32'h0001_2344, 1'b1);
                for (int i = 0; i < 4; i++) begin
                        read_and_check(32'h0001_2340 + i * 4, 1'b1);
                end
                // same index with another tag evicts the old line
                read_and_check(32'h0005_6348, 1'b1);
                read_and_check(32'h0001_234c, 1'b1);
                // uncacheable reads allocate nothing
                read_and_check(32'h0009_a128, 1'b0);
                read_and_check(32'h0009_a124, 1'b1);
                read_and_check(32'h0009_a120, 1'b0);

                for (int n = 0; n < random_reads; n++) begin
                        ar_delay <= 2'(take_bits(2));
                        r_delay <= 2'(take_bits(2));
                        pick_tag = tag_pool[2'(take_bits(2))];
                        pick_idx = idx_pool[2'(take_bits(2))];
                        pick_word = 2'(take_bits(2));
                        pick_cached = (take_bits(2) != 0);
                        read_and_check({pick_tag, pick_idx, pick_word, 2'b00}, pick_cached);
                end

                $display("errors %0d timeouts %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire
